// ==== logic/riscv_pkg.sv ====
package riscv_pkg;

  // basic widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes, rv32i base encoding
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // alu operations
  // pass_b forwards operand b, used by lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_t;

  // load/store access size
  typedef enum logic [1:0] {
    mem_byte,
    mem_byte_u,
    mem_word
  } mem_size_t;

  // all-zero payloads below are bubbles

  // fetch -> decode
  typedef struct packed {
    addr_t pc;
    data_t instr;
  } if_to_id_t;

  // decode -> execute
  typedef struct packed {
    addr_t     pc;
    data_t     rs1_val;
    data_t     rs2_val;
    data_t     imm;
    reg_idx_t  rd;
    alu_op_t   alu_op;
    mem_size_t mem_size;
    logic      alu_src_imm;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      branch;
    logic      branch_ne;
    logic      jump;
  } id_to_ex_t;

  // execute -> memory
  typedef struct packed {
    data_t     alu_result;
    data_t     store_data;
    reg_idx_t  rd;
    mem_size_t mem_size;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } ex_to_mem_t;

  // memory -> writeback
  typedef struct packed {
    data_t    result;
    reg_idx_t rd;
    logic     reg_write;
  } mem_to_wb_t;

endpackage

// ==== logic/pipe_reg.sv ====
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // priority: reset, flush, hold
  // reset and flush both load a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// ==== logic/fetch_stage.sv ====
module fetch_stage
  import riscv_pkg::*;
#(
  parameter addr_t reset_vector = '0
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  logic      redirect,
  input  addr_t     redirect_pc,
  output addr_t     imem_address,
  input  data_t     imem_read_data,
  output if_to_id_t if_to_id
);

  addr_t pc;

  // redirect wins over stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // rom reads combinationally
  assign imem_address = pc;

  // pc travels with its word
  assign if_to_id.pc    = pc;
  assign if_to_id.instr = imem_read_data;

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage
  import riscv_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  if_to_id_t if_to_id,
  input  data_t     wb_result,
  input  reg_idx_t  wb_rd,
  input  logic      wb_write,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output logic      rs1_used,
  output logic      rs2_used,
  output id_to_ex_t id_to_ex
);

  data_t     instr;
  data_t     regs [32];
  data_t     rs1_val;
  data_t     rs2_val;
  data_t     imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [2:0] funct3;
  logic       funct7_alt;
  id_to_ex_t  dec;
  logic       valid;
  logic       use_rs1;
  logic       use_rs2;

  assign instr      = if_to_id.instr;
  assign funct3     = instr[14:12];
  // bit 30 picks sub and sra
  assign funct7_alt = instr[30];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // register file write port, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_result;
    end
  end

  // read ports see a same-cycle write
  assign rs1_val = (rs1 == '0) ? '0 :
                   (wb_write && (wb_rd == rs1)) ? wb_result : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 :
                   (wb_write && (wb_rd == rs2)) ? wb_result : regs[rs2];

  always_comb begin
    dec         = '0;
    valid       = 1'b1;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    dec.pc      = if_to_id.pc;
    dec.rs1_val = rs1_val;
    dec.rs2_val = rs2_val;
    dec.rd      = instr[11:7];
    dec.alu_op  = alu_add;
    unique case (instr[6:0])
      op_lui: begin
        dec.imm         = imm_u;
        dec.alu_src_imm = 1'b1;
        dec.alu_op      = alu_pass_b;
        dec.reg_write   = 1'b1;
      end
      op_jal: begin
        // link value formed in execute
        dec.imm       = imm_j;
        dec.jump      = 1'b1;
        dec.reg_write = 1'b1;
      end
      op_branch: begin
        dec.imm       = imm_b;
        dec.branch    = 1'b1;
        dec.branch_ne = funct3[0];
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        // only beq and bne
        valid         = (funct3 == 3'b000) || (funct3 == 3'b001);
      end
      op_load: begin
        dec.imm         = imm_i;
        dec.alu_src_imm = 1'b1;
        dec.mem_read    = 1'b1;
        dec.reg_write   = 1'b1;
        use_rs1         = 1'b1;
        unique case (funct3)
          3'b000:  dec.mem_size = mem_byte;
          3'b100:  dec.mem_size = mem_byte_u;
          3'b010:  dec.mem_size = mem_word;
          default: valid = 1'b0;
        endcase
      end
      op_store: begin
        dec.imm         = imm_s;
        dec.alu_src_imm = 1'b1;
        dec.mem_write   = 1'b1;
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
        unique case (funct3)
          3'b000:  dec.mem_size = mem_byte;
          3'b010:  dec.mem_size = mem_word;
          default: valid = 1'b0;
        endcase
      end
      op_imm: begin
        dec.imm         = imm_i;
        dec.alu_src_imm = 1'b1;
        dec.reg_write   = 1'b1;
        use_rs1         = 1'b1;
        unique case (funct3)
          3'b000:  dec.alu_op = alu_add;
          3'b010:  dec.alu_op = alu_slt;
          3'b100:  dec.alu_op = alu_xor;
          3'b110:  dec.alu_op = alu_or;
          3'b111:  dec.alu_op = alu_and;
          // immediate shifts not supported
          default: valid = 1'b0;
        endcase
      end
      op_reg: begin
        dec.reg_write = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        unique case (funct3)
          3'b000:  dec.alu_op = funct7_alt ? alu_sub : alu_add;
          3'b001:  dec.alu_op = alu_sll;
          3'b010:  dec.alu_op = alu_slt;
          3'b100:  dec.alu_op = alu_xor;
          3'b101:  dec.alu_op = funct7_alt ? alu_sra : alu_srl;
          3'b110:  dec.alu_op = alu_or;
          3'b111:  dec.alu_op = alu_and;
          default: valid = 1'b0;
        endcase
      end
      default: valid = 1'b0;
    endcase
  end

  // unknown encodings turn into a bubble
  assign id_to_ex = valid ? dec : '0;
  assign rs1_used = valid & use_rs1;
  assign rs2_used = valid & use_rs2;

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage
  import riscv_pkg::*;
(
  input  id_to_ex_t  id_to_ex,
  output logic       redirect,
  output addr_t      redirect_pc,
  output ex_to_mem_t ex_to_mem
);

  data_t      op_a;
  data_t      op_b;
  data_t      alu_out;
  logic [4:0] shamt;
  logic       equal;
  logic       taken;

  assign op_a  = id_to_ex.rs1_val;
  assign op_b  = id_to_ex.alu_src_imm ? id_to_ex.imm : id_to_ex.rs2_val;
  // shifts use the low five bits only
  assign shamt = op_b[4:0];

  always_comb begin
    unique case (id_to_ex.alu_op)
      alu_add:    alu_out = op_a + op_b;
      alu_sub:    alu_out = op_a - op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_or:     alu_out = op_a | op_b;
      alu_xor:    alu_out = op_a ^ op_b;
      alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sll:    alu_out = op_a << shamt;
      alu_srl:    alu_out = op_a >> shamt;
      alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
      alu_pass_b: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // branch compare always on the two registers
  assign equal = (id_to_ex.rs1_val == id_to_ex.rs2_val);
  // bne inverts the sense of the compare
  assign taken = id_to_ex.branch & (equal ^ id_to_ex.branch_ne);

  // jal and branches share the pc-relative target
  assign redirect    = taken | id_to_ex.jump;
  assign redirect_pc = id_to_ex.pc + id_to_ex.imm;

  // jal writes the link address instead
  assign ex_to_mem.alu_result = id_to_ex.jump ? (id_to_ex.pc + 32'd4) : alu_out;
  assign ex_to_mem.store_data = id_to_ex.rs2_val;
  assign ex_to_mem.rd         = id_to_ex.rd;
  assign ex_to_mem.mem_size   = id_to_ex.mem_size;
  assign ex_to_mem.reg_write  = id_to_ex.reg_write;
  assign ex_to_mem.mem_read   = id_to_ex.mem_read;
  assign ex_to_mem.mem_write  = id_to_ex.mem_write;

endmodule

// ==== logic/memory_stage.sv ====
module memory_stage
  import riscv_pkg::*;
(
  input  ex_to_mem_t ex_to_mem,
  output addr_t      dmem_address,
  output data_t      dmem_write_data,
  output logic [3:0] dmem_write_enable,
  input  data_t      dmem_read_data,
  output mem_to_wb_t mem_to_wb
);

  logic [1:0] byte_off;
  logic [7:0] load_byte;
  data_t      load_value;
  logic       is_word;

  assign byte_off = ex_to_mem.alu_result[1:0];
  assign is_word  = (ex_to_mem.mem_size == mem_word);

  // word aligned, lanes pick the byte
  assign dmem_address = {ex_to_mem.alu_result[31:2], 2'b00};

  // byte store copies the byte to every lane
  assign dmem_write_data = is_word ? ex_to_mem.store_data : {4{ex_to_mem.store_data[7:0]}};

  always_comb begin
    if (!ex_to_mem.mem_write) begin
      dmem_write_enable = 4'b0000;
    end else if (is_word) begin
      dmem_write_enable = 4'b1111;
    end else begin
      dmem_write_enable = 4'b0001 << byte_off;
    end
  end

  // select the addressed byte lane
  assign load_byte = dmem_read_data[8*byte_off +: 8];

  always_comb begin
    unique case (ex_to_mem.mem_size)
      mem_byte:   load_value = {{24{load_byte[7]}}, load_byte};
      mem_byte_u: load_value = {24'b0, load_byte};
      default:    load_value = dmem_read_data;
    endcase
  end

  // final result leaves here, writeback only writes it
  assign mem_to_wb.result    = ex_to_mem.mem_read ? load_value : ex_to_mem.alu_result;
  assign mem_to_wb.rd        = ex_to_mem.rd;
  assign mem_to_wb.reg_write = ex_to_mem.reg_write;

endmodule

// ==== logic/hazard_unit.sv ====
module hazard_unit
  import riscv_pkg::*;
(
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     rs1_used,
  input  logic     rs2_used,
  input  reg_idx_t ex_rd,
  input  reg_idx_t mem_rd,
  input  logic     ex_reg_write,
  input  logic     mem_reg_write,
  input  logic     redirect,
  output logic     stall_front,
  output logic     flush_if_id,
  output logic     flush_id_ex
);

  logic rs1_hit;
  logic rs2_hit;
  logic raw;

  // x0 is never a real dependence
  // writeback stage not checked, regfile bypass covers it
  assign rs1_hit = rs1_used && (rs1 != '0) &&
                   ((ex_reg_write && (ex_rd == rs1)) || (mem_reg_write && (mem_rd == rs1)));
  assign rs2_hit = rs2_used && (rs2 != '0) &&
                   ((ex_reg_write && (ex_rd == rs2)) || (mem_reg_write && (mem_rd == rs2)));
  assign raw     = rs1_hit | rs2_hit;

  // redirect kills the stalled instruction anyway
  assign stall_front = raw & ~redirect;

  // bubble into execute on a stall or a taken redirect
  assign flush_id_ex = raw | redirect;
  assign flush_if_id = redirect;

endmodule

// ==== logic/riscv_pipelined.sv ====
module riscv_pipelined
  import riscv_pkg::*;
#(
  parameter addr_t reset_vector = '0
) (
  input  logic       clk,
  input  logic       reset,
  output addr_t      imem_address,
  input  data_t      imem_read_data,
  output addr_t      dmem_address,
  output data_t      dmem_write_data,
  output logic [3:0] dmem_write_enable,
  input  data_t      dmem_read_data
);

  // stage outputs and register outputs
  if_to_id_t  if_to_id_d, if_to_id_q;
  id_to_ex_t  id_to_ex_d, id_to_ex_q;
  ex_to_mem_t ex_to_mem_d, ex_to_mem_q;
  mem_to_wb_t mem_to_wb_d, mem_to_wb_q;

  // hazard wiring
  reg_idx_t rs1, rs2;
  logic     rs1_used, rs2_used;
  logic     stall_front;
  logic     flush_if_id;
  logic     flush_id_ex;

  // redirect from execute
  logic     redirect;
  addr_t    redirect_pc;

  fetch_stage #(
    .reset_vector (reset_vector)
  ) fetch_i (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall_front),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .imem_address   (imem_address),
    .imem_read_data (imem_read_data),
    .if_to_id       (if_to_id_d)
  );

  pipe_reg #(.payload_t(if_to_id_t)) if_id_reg (
    .clk   (clk),
    .reset (reset),
    .stall (stall_front),
    .flush (flush_if_id),
    .d     (if_to_id_d),
    .q     (if_to_id_q)
  );

  // writeback enters through the decode write port
  decode_stage decode_i (
    .clk       (clk),
    .reset     (reset),
    .if_to_id  (if_to_id_q),
    .wb_result (mem_to_wb_q.result),
    .wb_rd     (mem_to_wb_q.rd),
    .wb_write  (mem_to_wb_q.reg_write),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_used  (rs1_used),
    .rs2_used  (rs2_used),
    .id_to_ex  (id_to_ex_d)
  );

  pipe_reg #(.payload_t(id_to_ex_t)) id_ex_reg (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (flush_id_ex),
    .d     (id_to_ex_d),
    .q     (id_to_ex_q)
  );

  execute_stage execute_i (
    .id_to_ex    (id_to_ex_q),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_to_mem   (ex_to_mem_d)
  );

  // back half never stalls
  pipe_reg #(.payload_t(ex_to_mem_t)) ex_mem_reg (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (1'b0),
    .d     (ex_to_mem_d),
    .q     (ex_to_mem_q)
  );

  memory_stage memory_i (
    .ex_to_mem         (ex_to_mem_q),
    .dmem_address      (dmem_address),
    .dmem_write_data   (dmem_write_data),
    .dmem_write_enable (dmem_write_enable),
    .dmem_read_data    (dmem_read_data),
    .mem_to_wb         (mem_to_wb_d)
  );

  pipe_reg #(.payload_t(mem_to_wb_t)) mem_wb_reg (
    .clk   (clk),
    .reset (reset),
    .stall (1'b0),
    .flush (1'b0),
    .d     (mem_to_wb_d),
    .q     (mem_to_wb_q)
  );

  // sources checked against execute and memory destinations
  hazard_unit hazard_i (
    .rs1           (rs1),
    .rs2           (rs2),
    .rs1_used      (rs1_used),
    .rs2_used      (rs2_used),
    .ex_rd         (id_to_ex_q.rd),
    .mem_rd        (ex_to_mem_q.rd),
    .ex_reg_write  (id_to_ex_q.reg_write),
    .mem_reg_write (ex_to_mem_q.reg_write),
    .redirect      (redirect),
    .stall_front   (stall_front),
    .flush_if_id   (flush_if_id),
    .flush_id_ex   (flush_id_ex)
  );

endmodule

// ==== dv/tb_memory.sv ====
module tb_memory (
  input  logic        clk,
  input  logic [31:0] imem_address,
  output logic [31:0] imem_read_data,
  input  logic [31:0] dmem_address,
  input  logic [31:0] dmem_write_data,
  input  logic [3:0]  dmem_write_enable,
  output logic [31:0] dmem_read_data
);

  // 1 KiB each, word indexed
  logic [31:0] rom [256];
  logic [31:0] ram [256];

  // both ports read combinationally
  assign imem_read_data = rom[imem_address[9:2]];
  assign dmem_read_data = ram[dmem_address[9:2]];

  // byte lanes commit on the rising edge
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_write_enable[b]) begin
        ram[dmem_address[9:2]][8*b +: 8] <= dmem_write_data[8*b +: 8];
      end
    end
  end

endmodule

// ==== dv/riscv_tb.sv ====
module riscv_tb;

  localparam int         store_timeout = 40;
  localparam int         quiet_cycles  = 20;
  localparam logic [31:0] boot_pc      = 32'h0;
  localparam logic [6:0] opc_imm       = 7'b0010011;
  localparam logic [6:0] opc_load      = 7'b0000011;

  logic        clk;
  logic        reset;
  logic [31:0] imem_address;
  logic [31:0] imem_read_data;
  logic [31:0] dmem_address;
  logic [31:0] dmem_write_data;
  logic [3:0]  dmem_write_enable;
  logic [31:0] dmem_read_data;

  // program words and the expected stores in program order
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [3:0]  exp_mask [$];
  logic [31:0] exp_data [$];
  // architectural register values as the ISA defines them
  logic [31:0] x [32];
  logic [31:0] operand [4];
  logic [31:0] rng_state;

  riscv_pipelined #(.reset_vector(boot_pc)) dut_i (
    .clk               (clk),
    .reset             (reset),
    .imem_address      (imem_address),
    .imem_read_data    (imem_read_data),
    .dmem_address      (dmem_address),
    .dmem_write_data   (dmem_write_data),
    .dmem_write_enable (dmem_write_enable),
    .dmem_read_data    (dmem_read_data)
  );

  tb_memory mem_i (
    .clk               (clk),
    .imem_address      (imem_address),
    .imem_read_data    (imem_read_data),
    .dmem_address      (dmem_address),
    .dmem_write_data   (dmem_write_data),
    .dmem_write_enable (dmem_write_enable),
    .dmem_read_data    (dmem_read_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // byte lane mask widened to bit mask
  function automatic logic [31:0] lane_bits(logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // rv32i encoders
  function automatic logic [31:0] r_type(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // stores always use x0 as base
  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic emit(logic [31:0] w);
    prog.push_back(w);
  endtask

  // sw plus its expected bus beat
  task automatic word_store(logic [4:0] rs2, logic [11:0] offset, logic [31:0] value);
    emit(s_type(offset, rs2, 3'b010));
    exp_addr.push_back(sext12(offset));
    exp_mask.push_back(4'b1111);
    exp_data.push_back(value);
  endtask

  // sb sets a one-hot lane and copies the byte to all lanes
  task automatic byte_store(logic [4:0] rs2, logic [11:0] offset, logic [7:0] value);
    emit(s_type(offset, rs2, 3'b000));
    exp_addr.push_back(sext12(offset) & 32'hffff_fffc);
    exp_mask.push_back(4'b0001 << offset[1:0]);
    exp_data.push_back({4{value}});
  endtask

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check(string what, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      fail_now($sformatf("ERR @%0t: %s got %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic build_program();
    int jal_pc;
    // lui then a dependent store at distance one
    emit(u_type(20'h12345, 1));
    x[1] = 32'h12345000;
    word_store(1, 12'h200, x[1]);
    emit(i_type(12'hf9c, 0, 3'b000, 2, opc_imm));
    x[2] = sext12(12'hf9c);
    emit(i_type(12'h007, 0, 3'b000, 3, opc_imm));
    x[3] = sext12(12'h007);
    emit(i_type(12'h0f0, 1, 3'b110, 4, opc_imm));
    x[4] = x[1] | sext12(12'h0f0);
    emit(i_type(12'h0ff, 4, 3'b111, 5, opc_imm));
    x[5] = x[4] & sext12(12'h0ff);
    emit(i_type(12'h555, 2, 3'b100, 6, opc_imm));
    x[6] = x[2] ^ sext12(12'h555);
    // slti with a negative value below 5 and 7 not below -1
    emit(i_type(12'h005, 2, 3'b010, 7, opc_imm));
    x[7] = ($signed(x[2]) < $signed(sext12(12'h005))) ? 32'd1 : 32'd0;
    emit(i_type(12'hfff, 3, 3'b010, 8, opc_imm));
    x[8] = ($signed(x[3]) < $signed(sext12(12'hfff))) ? 32'd1 : 32'd0;
    emit(r_type(1'b0, 3, 2, 3'b000, 9));
    x[9] = x[2] + x[3];
    emit(r_type(1'b1, 2, 3, 3'b000, 10));
    x[10] = x[3] - x[2];
    emit(r_type(1'b0, 6, 4, 3'b111, 11));
    x[11] = x[4] & x[6];
    emit(r_type(1'b0, 6, 4, 3'b110, 12));
    x[12] = x[4] | x[6];
    emit(r_type(1'b0, 6, 4, 3'b100, 13));
    x[13] = x[4] ^ x[6];
    emit(r_type(1'b0, 3, 2, 3'b010, 14));
    x[14] = ($signed(x[2]) < $signed(x[3])) ? 32'd1 : 32'd0;
    emit(r_type(1'b0, 2, 3, 3'b010, 15));
    x[15] = ($signed(x[3]) < $signed(x[2])) ? 32'd1 : 32'd0;
    // shifts by x3 with srl and sra on a negative value
    emit(r_type(1'b0, 3, 3, 3'b001, 16));
    x[16] = x[3] << x[3][4:0];
    emit(r_type(1'b0, 3, 2, 3'b101, 17));
    x[17] = x[2] >> x[3][4:0];
    emit(r_type(1'b1, 3, 2, 3'b101, 18));
    x[18] = $signed(x[2]) >>> x[3][4:0];
    for (int r = 2; r <= 18; r++) begin
      word_store(r, 12'h200 + 4 * (r - 1), x[r]);
    end
    // dependence distances one, two and three
    emit(i_type(12'd11, 0, 3'b000, 20, opc_imm));
    emit(i_type(12'd5, 20, 3'b000, 21, opc_imm));
    x[21] = 32'd11 + 32'd5;
    emit(i_type(12'd3, 0, 3'b000, 22, opc_imm));
    emit(r_type(1'b0, 22, 21, 3'b000, 23));
    x[23] = x[21] + 32'd3;
    emit(i_type(12'd1, 0, 3'b000, 24, opc_imm));
    emit(i_type(12'd2, 0, 3'b000, 25, opc_imm));
    emit(r_type(1'b0, 21, 23, 3'b000, 26));
    x[26] = x[23] + x[21];
    word_store(21, 12'h260, x[21]);
    word_store(23, 12'h264, x[23]);
    word_store(26, 12'h268, x[26]);
    // loads of the preset operands used right away
    emit(i_type(12'h100, 0, 3'b010, 1, opc_load));
    emit(i_type(12'h104, 0, 3'b010, 2, opc_load));
    emit(r_type(1'b0, 2, 1, 3'b000, 3));
    x[1] = operand[0];
    x[3] = operand[0] + operand[1];
    word_store(3, 12'h270, x[3]);
    emit(i_type(12'h109, 0, 3'b000, 4, opc_load));
    x[4] = {{24{operand[2][15]}}, operand[2][15:8]};
    emit(i_type(12'h10e, 0, 3'b100, 5, opc_load));
    x[5] = {24'b0, operand[3][23:16]};
    emit(r_type(1'b0, 5, 4, 3'b000, 6));
    word_store(4, 12'h274, x[4]);
    word_store(5, 12'h278, x[5]);
    word_store(6, 12'h27c, x[4] + x[5]);
    // sb to every byte offset of one word
    for (int b = 0; b < 4; b++) begin
      byte_store(1, 12'h280 + b, x[1][7:0]);
    end
    // taken beq skips two stores and bne falls through
    emit(i_type(12'd9, 0, 3'b000, 8, opc_imm));
    emit(i_type(12'd9, 0, 3'b000, 9, opc_imm));
    emit(b_type(13'd12, 9, 8, 3'b000));
    emit(s_type(12'h2f0, 8, 3'b010));
    emit(s_type(12'h2f4, 8, 3'b010));
    emit(b_type(13'd8, 9, 8, 3'b001));
    word_store(8, 12'h284, 32'd9);
    // jal skips two stores and links its pc plus 4
    jal_pc = prog.size() * 4;
    emit(j_type(21'd12, 10));
    emit(s_type(12'h2f8, 8, 3'b010));
    emit(s_type(12'h2fc, 8, 3'b010));
    word_store(10, 12'h288, jal_pc + 4);
    // x0 stays zero
    emit(i_type(12'd77, 0, 3'b000, 0, opc_imm));
    word_store(0, 12'h28c, 32'd0);
    // park in a self loop
    emit(j_type(21'd0, 0));
  endtask

  initial begin
    int waited;
    reset     = 1'b1;
    rng_state = 32'hcb95;
    // rom full of nops and ram full of random words
    for (int i = 0; i < 256; i++) begin
      mem_i.rom[i] = 32'h00000013;
      rng_state    = xorshift(rng_state);
      mem_i.ram[i] = rng_state;
    end
    // operands live at 0x100
    for (int j = 0; j < 4; j++) begin
      operand[j] = mem_i.ram[64 + j];
    end
    build_program();
    foreach (prog[i]) begin
      mem_i.rom[i] = prog[i];
    end

    repeat (3) @(negedge clk);
    reset = 1'b0;

    // first fetch comes from the reset vector with only bubbles behind it
    check("fetch address after reset", imem_address, boot_pc);
    check("store enable after reset", {28'b0, dmem_write_enable}, 32'h0);

    // bus sampled mid-cycle before the beat commits at the next rising edge
    for (int k = 0; k < exp_addr.size(); k++) begin
      waited = 0;
      @(negedge clk);
      while (dmem_write_enable == 4'b0000) begin
        waited++;
        if (waited > store_timeout) begin
          fail_now($sformatf("timeout: store %0d never appeared within %0d cycles",
                             k, store_timeout));
        end
        @(negedge clk);
      end
      check($sformatf("store %0d address", k), dmem_address, exp_addr[k]);
      check($sformatf("store %0d mask", k), {28'b0, dmem_write_enable}, {28'b0, exp_mask[k]});
      // only enabled lanes carry meaning
      check($sformatf("store %0d data", k), dmem_write_data & lane_bits(exp_mask[k]),
            exp_data[k] & lane_bits(exp_mask[k]));
    end

    // self loop must stay quiet
    for (int c = 0; c < quiet_cycles; c++) begin
      @(negedge clk);
      if (dmem_write_enable != 4'b0000) begin
        fail_now($sformatf("an extra store to address %h came after the last expected one",
                           dmem_address));
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== sim.f ====
logic/riscv_pkg.sv
logic/pipe_reg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/riscv_pipelined.sv
dv/tb_memory.sv
dv/riscv_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_pipelined

sources:
  - logic/riscv_pkg.sv
  - logic/pipe_reg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/hazard_unit.sv
  - logic/riscv_pipelined.sv
  - target: simulation
    files:
      - dv/tb_memory.sv
      - dv/riscv_tb.sv
